// File: counter_pkg.sv
package counter_pkg;

        ////////////////////////////////////////////////////////////
        // Sizes and divider lengths
        ////////////////////////////////////////////////////////////

        localparam int NUM_DIGITS = 4;

        // Short dividers keep simulation fast; widen for a board build
        localparam int DEBOUNCE_TICK_BITS = 6;   // Sample every 64 cycles
        localparam int SCAN_TICK_BITS     = 3;   // Next digit every 8 cycles

        ////////////////////////////////////////////////////////////
        // Types
        ////////////////////////////////////////////////////////////

        typedef logic [3:0] bcd_digit_t;

        // Digit 0 sits in the lowest nibble
        typedef logic [NUM_DIGITS*4-1:0] bcd_count_t;

        // Active low, bit 0 = a .. bit 6 = g, bit 7 = dp
        typedef logic [7:0] seg_t;

        // Active low commons, bit i enables digit i
        typedef logic [NUM_DIGITS-1:0] com_t;

        typedef enum logic [1:0] {
                DIGIT0 = 2'd0,
                DIGIT1 = 2'd1,
                DIGIT2 = 2'd2,
                DIGIT3 = 2'd3
        } scan_state_t;

endpackage

// File: button_conditioner.sv
`timescale 1ns/1ps

module button_conditioner import counter_pkg::*; (
        input  logic clk,
        input  logic reset_p,
        input  logic btn,
        output logic press
);

        logic [DEBOUNCE_TICK_BITS-1:0] div_q;
        logic sample_tick;
        logic btn_sampled;
        logic edge_cur;
        logic edge_old;

        ////////////////////////////////////////////////////////////
        // Debounce divider and sampling
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p) begin
                        div_q <= '0;
                end else begin
                        div_q <= div_q + 1'b1;   // Free running
                end
        end

        assign sample_tick = &div_q;   // Once per divider wrap

        // Bounces shorter than one tick period never reach btn_sampled
        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p) begin
                        btn_sampled <= 1'b0;
                end else if (sample_tick) begin
                        btn_sampled <= btn;
                end
        end

        ////////////////////////////////////////////////////////////
        // Rising edge to one-cycle pulse
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p) begin
                        edge_cur <= 1'b0;
                        edge_old <= 1'b0;
                        press    <= 1'b0;
                end else begin
                        edge_cur <= btn_sampled;
                        edge_old <= edge_cur;
                        press    <= edge_cur & ~edge_old;   // Low to high only
                end
        end

        // A held button must not repeat
        a_press_single: assert property (
                @(posedge clk) disable iff (reset_p) press |=> !press
        ) else $error("press high on two consecutive cycles");

endmodule

// File: bcd_updown_counter.sv
`timescale 1ns/1ps

module bcd_updown_counter import counter_pkg::*; (
        input  logic       clk,
        input  logic       reset_p,
        input  logic       up_press,
        input  logic       down_press,
        output bcd_count_t bcd_count
);

        bcd_digit_t digit_q [NUM_DIGITS];

        logic                  count_up;
        logic [NUM_DIGITS-1:0] step;   // Digit i moves this cycle

        ////////////////////////////////////////////////////////////
        // Direction and carry / borrow chain
        ////////////////////////////////////////////////////////////

        // Up wins when both pulses land together
        assign count_up = up_press;
        assign step[0]  = up_press | down_press;

        genvar i;
        for (i = 0; i < NUM_DIGITS; i++) begin : g_digit
                logic at_limit;

                // 9 going up, 0 going down
                assign at_limit = count_up ? (digit_q[i] == bcd_digit_t'(9))
                                           : (digit_q[i] == bcd_digit_t'(0));

                if (i < NUM_DIGITS - 1) begin : g_chain
                        assign step[i+1] = step[i] & at_limit;   // Ripple into next digit
                end

                always_ff @(posedge clk or posedge reset_p) begin
                        if (reset_p) begin
                                digit_q[i] <= '0;
                        end else if (step[i]) begin
                                if (count_up) begin
                                        digit_q[i] <= at_limit ? bcd_digit_t'(0)
                                                               : digit_q[i] + 1'b1;
                                end else begin
                                        digit_q[i] <= at_limit ? bcd_digit_t'(9)
                                                               : digit_q[i] - 1'b1;
                                end
                        end
                end

                assign bcd_count[i*4 +: 4] = digit_q[i];

                // Wrap logic keeps every digit decimal
                a_digit_range: assert property (
                        @(posedge clk) disable iff (reset_p) digit_q[i] <= bcd_digit_t'(9)
                ) else $error("digit %0d left the BCD range", i);
        end

endmodule

// File: digit_scanner.sv
`timescale 1ns/1ps

module digit_scanner import counter_pkg::*; (
        input  logic       clk,
        input  logic       reset_p,
        input  bcd_count_t bcd_count,
        output com_t       com,
        output seg_t       seg
);

        logic [SCAN_TICK_BITS-1:0] div_q;
        logic        scan_tick;
        scan_state_t state_q;
        scan_state_t state_next;
        bcd_digit_t  cur_digit;
        com_t        com_next;

        // Standard glyphs, active low, dp kept off
        function automatic seg_t decode_7seg(input bcd_digit_t value);
                seg_t glyph;
                case (value)
                        4'd0:    glyph = 8'b1100_0000;
                        4'd1:    glyph = 8'b1111_1001;
                        4'd2:    glyph = 8'b1010_0100;
                        4'd3:    glyph = 8'b1011_0000;
                        4'd4:    glyph = 8'b1001_1001;
                        4'd5:    glyph = 8'b1001_0010;
                        4'd6:    glyph = 8'b1000_0010;
                        4'd7:    glyph = 8'b1111_1000;
                        4'd8:    glyph = 8'b1000_0000;
                        4'd9:    glyph = 8'b1001_0000;
                        default: glyph = 8'b1111_1111;   // Blank
                endcase
                return glyph;
        endfunction

        ////////////////////////////////////////////////////////////
        // Scan divider and digit FSM
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p) begin
                        div_q <= '0;
                end else begin
                        div_q <= div_q + 1'b1;
                end
        end

        assign scan_tick = &div_q;

        always_comb begin
                case (state_q)
                        DIGIT0:  state_next = DIGIT1;
                        DIGIT1:  state_next = DIGIT2;
                        DIGIT2:  state_next = DIGIT3;
                        default: state_next = DIGIT0;
                endcase
        end

        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p) begin
                        state_q <= DIGIT0;
                end else if (scan_tick) begin
                        state_q <= state_next;
                end
        end

        ////////////////////////////////////////////////////////////
        // Digit select and output registers
        ////////////////////////////////////////////////////////////

        assign cur_digit = bcd_count[state_q*4 +: 4];
        assign com_next  = ~(com_t'(1) << state_q);   // One low common

        // Registered together so seg always matches the active common
        always_ff @(posedge clk or posedge reset_p) begin
                if (reset_p) begin
                        com <= com_t'(4'b1110);
                        seg <= decode_7seg(bcd_digit_t'(0));
                end else begin
                        com <= com_next;
                        seg <= decode_7seg(cur_digit);
                end
        end

        a_one_common: assert property (
                @(posedge clk) disable iff (reset_p) $onehot(~com)
        ) else $error("com does not enable exactly one digit");

endmodule

// File: updown_display_top.sv
`timescale 1ns/1ps

module updown_display_top import counter_pkg::*; (
        input  logic       clk,
        input  logic       reset_p,
        input  logic       btn_up,
        input  logic       btn_down,
        output com_t       com,
        output seg_t       seg,
        output bcd_count_t bcd_count
);

        logic up_press;
        logic down_press;

        ////////////////////////////////////////////////////////////
        // Buttons
        ////////////////////////////////////////////////////////////

        button_conditioner u_btn_up (
                .clk     (clk),
                .reset_p (reset_p),
                .btn     (btn_up),
                .press   (up_press)
        );

        button_conditioner u_btn_down (
                .clk     (clk),
                .reset_p (reset_p),
                .btn     (btn_down),
                .press   (down_press)
        );

        ////////////////////////////////////////////////////////////
        // Count and display
        ////////////////////////////////////////////////////////////

        bcd_updown_counter u_counter (
                .clk        (clk),
                .reset_p    (reset_p),
                .up_press   (up_press),
                .down_press (down_press),
                .bcd_count  (bcd_count)   // Also drives the LEDs
        );

        digit_scanner u_scanner (
                .clk       (clk),
                .reset_p   (reset_p),
                .bcd_count (bcd_count),
                .com       (com),
                .seg       (seg)
        );

endmodule

// File: tb_updown_display.sv
`timescale 1ns/1ps

module tb_updown_display import counter_pkg::*; ();

        localparam int CLK_PERIOD      = 100;
        localparam int COUNT_RANGE     = 10000;
        localparam int HOLD_MIN        = 80;
        localparam int HOLD_MAX        = 200;
        localparam int STEP_TIMEOUT    = 70;   // Cycles from press to count change
        localparam int NUM_RANDOM      = 12;
        localparam int NUM_PRESSES     = 2 + 12 + 1 + NUM_RANDOM;
        localparam int PRESS_CYCLES    = 2 * HOLD_MAX;   // Longest hold plus release
        localparam int WATCHDOG_CYCLES = NUM_PRESSES * PRESS_CYCLES + 1000;

        logic       clk;
        logic       reset_p;
        logic       btn_up;
        logic       btn_down;
        com_t       com;
        seg_t       seg;
        bcd_count_t bcd_count;

        bcd_count_t model_count;
        bcd_count_t seen_count;
        bcd_count_t exp_q [$];   // Counts still to appear on bcd_count
        integer     seed;
        int         value_errors;
        int         other_errors;

        updown_display_top u_dut (
                .clk       (clk),
                .reset_p   (reset_p),
                .btn_up    (btn_up),
                .btn_down  (btn_down),
                .com       (com),
                .seg       (seg),
                .bcd_count (bcd_count)
        );

        initial clk = 1'b0;
        always #(CLK_PERIOD / 2) clk = ~clk;

        ////////////////////////////////////////////////////////////
        // Reference model and display tables
        ////////////////////////////////////////////////////////////

        // Decimal value stepped by one, wrapping at both ends
        function automatic bcd_count_t next_count(input bcd_count_t count, input logic up);
                int         value;
                bcd_count_t result;
                value = 0;
                for (int d = NUM_DIGITS - 1; d >= 0; d--) begin
                        value = value * 10 + int'(count[d*4 +: 4]);
                end
                if (up) begin
                        value = (value + 1) % COUNT_RANGE;
                end else begin
                        value = (value + COUNT_RANGE - 1) % COUNT_RANGE;
                end
                for (int d = 0; d < NUM_DIGITS; d++) begin
                        result[d*4 +: 4] = bcd_digit_t'(value % 10);
                        value = value / 10;
                end
                return result;
        endfunction

        // Lit segments, bit 0 = a .. bit 6 = g
        function automatic seg_t glyph_for(input int value);
                logic [6:0] lit;
                case (value)
                        0:       lit = 7'h3f;
                        1:       lit = 7'h06;
                        2:       lit = 7'h5b;
                        3:       lit = 7'h4f;
                        4:       lit = 7'h66;
                        5:       lit = 7'h6d;
                        6:       lit = 7'h7d;
                        7:       lit = 7'h07;
                        8:       lit = 7'h7f;
                        9:       lit = 7'h6f;
                        default: lit = 7'h00;
                endcase
                return {1'b1, ~lit};   // Active low, dp off
        endfunction

        function automatic int decode_glyph(input seg_t pattern);
                int found;
                found = -1;   // No valid digit shape
                for (int v = 0; v < 10; v++) begin
                        if (glyph_for(v) == pattern) begin
                                found = v;
                        end
                end
                return found;
        endfunction

        task automatic check_value(input string name, input logic [15:0] actual,
                                   input logic [15:0] expected);
                assert (actual === expected) else begin
                        $display("FAILED at %0t: %s expected %h, got %h",
                                 $time, name, expected, actual);
                        value_errors++;
                end
        endtask

        ////////////////////////////////////////////////////////////
        // Count comparison, sampled mid-cycle
        ////////////////////////////////////////////////////////////

        always @(negedge clk) begin : compare_count
                bcd_count_t expected;
                if (reset_p) begin
                        seen_count = '0;
                end else if (bcd_count !== seen_count) begin
                        assert (exp_q.size() > 0) else begin
                                $display("Count changed from %h to %h at %0t with no press pending",
                                         seen_count, bcd_count, $time);
                                other_errors++;
                        end
                        if (exp_q.size() > 0) begin
                                expected = exp_q.pop_front();
                                check_value("bcd_count", bcd_count, expected);
                        end
                        seen_count = bcd_count;
                end
        end

        ////////////////////////////////////////////////////////////
        // Stimulus tasks
        ////////////////////////////////////////////////////////////

        task automatic press_button(input logic up, input int hold_cycles,
                                    input int release_cycles);
                int waited;
                waited = 0;
                @(negedge clk);
                model_count = next_count(model_count, up);
                exp_q.push_back(model_count);
                if (up) begin
                        btn_up = 1'b1;
                end else begin
                        btn_down = 1'b1;
                end
                // Queue drains on the negedge, polled on the posedge
                while (exp_q.size() > 0 && waited < STEP_TIMEOUT) begin
                        @(posedge clk);
                        waited++;
                end
                assert (exp_q.size() == 0) else begin
                        $display("No count change within %0d cycles of a %s press at %0t",
                                 STEP_TIMEOUT, up ? "up" : "down", $time);
                        other_errors++;
                        exp_q.delete();
                end
                repeat (hold_cycles - waited) @(negedge clk);
                btn_up   = 1'b0;
                btn_down = 1'b0;
                repeat (release_cycles) @(negedge clk);
        endtask

        // seg must show the active digit of the previous cycle's count
        task automatic check_display(input int cycles);
                bcd_count_t            last_count;
                logic [NUM_DIGITS-1:0] digits_seen;
                int                    idx;
                int                    shown;
                digits_seen = '0;
                @(negedge clk);
                last_count = bcd_count;
                repeat (cycles) begin
                        @(negedge clk);
                        idx = -1;
                        for (int d = 0; d < NUM_DIGITS; d++) begin
                                if (com == ~(com_t'(1) << d)) begin
                                        idx = d;
                                end
                        end
                        shown = decode_glyph(seg);
                        assert (idx >= 0) else begin
                                $display("At %0t com %b does not enable exactly one digit",
                                         $time, com);
                                other_errors++;
                        end
                        if (idx >= 0) begin
                                digits_seen[idx] = 1'b1;
                                assert (shown == int'(last_count[idx*4 +: 4])) else begin
                                        $display("FAILED at %0t: seg digit %0d expected %0d, got %0d",
                                                 $time, idx, last_count[idx*4 +: 4], shown);
                                        value_errors++;
                                end
                        end
                        last_count = bcd_count;
                end
                assert (&digits_seen) else begin
                        $display("Scan over %0d cycles missed digits, seen mask %b",
                                 cycles, digits_seen);
                        other_errors++;
                end
        endtask

        ////////////////////////////////////////////////////////////
        // Test sequence
        ////////////////////////////////////////////////////////////

        initial begin : stimulus
                logic [31:0] rnd;
                logic        up_dir;
                int          hold;
                reset_p      = 1'b1;
                btn_up       = 1'b0;
                btn_down     = 1'b0;
                seed         = 32'h86d1a072;
                value_errors = 0;
                other_errors = 0;
                model_count  = '0;
                repeat (3) @(negedge clk);

                // Registers still held in reset
                check_value("bcd_count", bcd_count, 16'h0000);
                check_value("com", 16'(com), 16'h000e);
                check_value("seg", 16'(seg), 16'(glyph_for(0)));
                reset_p = 1'b0;

                press_button(1'b0, 100, 100);   // 0000 wraps down
                check_value("bcd_count", bcd_count, 16'h9999);
                press_button(1'b1, 100, 100);
                check_value("bcd_count", bcd_count, 16'h0000);

                // Passes the 0009 to 0010 carry
                repeat (12) press_button(1'b1, HOLD_MIN, HOLD_MIN);
                check_value("bcd_count", bcd_count, 16'h0012);

                press_button(1'b1, 300, 100);   // Long hold, single step
                check_value("bcd_count", bcd_count, 16'h0013);

                for (int n = 0; n < NUM_RANDOM; n++) begin
                        rnd    = $random(seed);
                        up_dir = rnd[0];
                        rnd    = $random(seed);
                        hold   = HOLD_MIN + int'(rnd[7:0]) % (HOLD_MAX - HOLD_MIN + 1);
                        press_button(up_dir, hold, hold);
                end

                check_display(32);

                $display("Checks done: %0d value errors, %0d other errors",
                         value_errors, other_errors);
                if (value_errors + other_errors == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

        initial begin : watchdog
                #(WATCHDOG_CYCLES * CLK_PERIOD);
                $display("Watchdog expired after %0d cycles before the tests finished",
                         WATCHDOG_CYCLES);
                $display("Checks done: %0d value errors, %0d other errors",
                         value_errors, other_errors);
                $display("CHECKS FAILED");
                $finish;
        end

endmodule

// File: build.f
counter_pkg.sv
button_conditioner.sv
bcd_updown_counter.sv
digit_scanner.sv
updown_display_top.sv
tb_updown_display.sv

// File: Makefile
TOP := tb_updown_display

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module $(TOP) -o V$(TOP)

# Pass only when the simulation prints the pass message
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
